// File: Bender.yml
package:
  name: rv32i_core

sources:
  - hw/rv_isa_pkg.sv
  - hw/rv_ctrl_pkg.sv
  - hw/control.sv
  - hw/imm_extend.sv
  - hw/alu.sv
  - hw/pc_unit.sv
  - hw/reg_file.sv
  - hw/data_ram.sv
  - hw/cpu_top.sv
  - target: test
    files:
      - bench/tb_clk_gen.sv
      - bench/tb_cpu.sv

// File: bench/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk_o,   // 4 ns period
    output logic rst_n_o  // low for the first two cycles
);

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    initial begin
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o <= 1'b1; // released on a falling edge
    end

endmodule

// File: bench/tb_cpu.sv
`timescale 1ns/1ns

module tb_cpu;

    localparam rv_isa_pkg::word_t NOP      = 32'h0000_0013; // addi x0, x0, 0
    localparam rv_isa_pkg::word_t FILL     = 32'hfff0_0513; // addi x10, x0, -1 on skipped slots
    localparam rv_isa_pkg::word_t JAL_SELF = 32'h0000_006f; // jal x0, 0
    localparam int                LIMIT    = 400;           // cycles before timeout

    logic              clk;
    logic              rst_n;
    rv_isa_pkg::word_t instr = NOP;
    rv_isa_pkg::word_t pc;
    rv_isa_pkg::word_t a0;

    rv_isa_pkg::word_t prog     [96]; // program store with one word per slot
    rv_isa_pkg::word_t exp_next [96]; // pc after the slot executes
    rv_isa_pkg::word_t exp_a0   [96];
    logic              chk_a0   [96]; // slot writes x10
    string             tname    [96];
    int                n_instr    = 0;
    int                last_idx   = -1; // -1 until the first fetch
    int                val_errs   = 0;
    int                other_errs = 0;
    logic              prog_done  = 1'b0;

    tb_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    cpu_top #(.RAM_ADDR_W(10)) u_dut (
        .clk_i(clk), .rst_n_i(rst_n), .instr_i(instr), .pc_o(pc), .a0_o(a0)
    );

    function automatic rv_isa_pkg::word_t r_type(input logic [2:0] f3, input logic alt,
                                                 input logic [4:0] rd, rs1, rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rv_isa_pkg::OP_R};
    endfunction

    function automatic rv_isa_pkg::word_t i_type(input logic [6:0] op, input logic [2:0] f3,
                                                 input logic [4:0] rd, rs1,
                                                 input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_isa_pkg::word_t s_type(input logic [2:0] f3, input logic [4:0] rs1,
                                                 rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_isa_pkg::OP_STORE};
    endfunction

    function automatic rv_isa_pkg::word_t b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                                 rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::OP_BRANCH};
    endfunction

    function automatic rv_isa_pkg::word_t jal_enc(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::OP_JAL};
    endfunction

    // rv32i arithmetic with shift amounts from the low 5 bits of b
    function automatic rv_isa_pkg::word_t arith_ref(input logic [2:0] f3, input logic alt,
                                                    input rv_isa_pkg::word_t a, b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input rv_isa_pkg::word_t a, b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            default: return $signed(a) >= $signed(b); // bge
        endcase
    endfunction

    task automatic put(input rv_isa_pkg::word_t ins, input string name,
                       input rv_isa_pkg::word_t nxt, input logic chk, input rv_isa_pkg::word_t val);
        prog[n_instr]     = ins;
        tname[n_instr]    = name;
        exp_next[n_instr] = nxt;
        chk_a0[n_instr]   = chk;
        exp_a0[n_instr]   = val;
        n_instr++;
    endtask

    task automatic value_error(input string name, input rv_isa_pkg::word_t exp, act);
        val_errs++;
        $display("** Error %s: expected %h, actual %h", name, exp, act);
    endtask

    // check the slot that just committed, then fetch the next one
    always @(negedge clk) begin : fetch
        int idx;
        if (!rst_n) begin
            assert (pc == '0) else value_error("reset pc", '0, pc);
            assert (a0 == '0) else value_error("reset a0", '0, a0);
        end else if (last_idx < n_instr) begin
            assert (pc == exp_next[last_idx]) else
                value_error({tname[last_idx], " pc"}, exp_next[last_idx], pc);
            if (chk_a0[last_idx]) begin
                assert (a0 == exp_a0[last_idx]) else
                    value_error({tname[last_idx], " a0"}, exp_a0[last_idx], a0);
            end
        end
        idx      = pc >> 2;
        instr   <= (idx < n_instr) ? prog[idx] : JAL_SELF; // endless loop past the end
        last_idx = (idx < n_instr) ? idx : n_instr;
        if (idx >= n_instr) prog_done = 1'b1;
    end

    initial begin : run
        logic [11:0]       ia, ib, addr;
        rv_isa_pkg::word_t va, vb, vw, imm;
        logic [4:0]        rs1, rs2;
        logic [2:0]        f3b;
        logic              taken;
        int                k, tgt, cycles;
        void'($urandom(32'h371f_91ad)); // seeds the generator
        ia = 12'($urandom) | 12'h800; // negative so signed and unsigned ops differ
        ib = (12'($urandom) & 12'h7f7) | 12'h090; // positive with bit 7 set and shift 16 to 23
        va = {{20{ia[11]}}, ia};
        vb = {{20{ib[11]}}, ib};
        put(i_type(rv_isa_pkg::OP_IMM, 0, 5, 0, ia), "addi x5", 4*n_instr + 4, 0, 0);
        put(i_type(rv_isa_pkg::OP_IMM, 0, 6, 0, ib), "addi x6", 4*n_instr + 4, 0, 0);
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 1 && f3 != 0 && f3 != 5) continue; // only sub and sra
                put(r_type(f3, alt, 10, 5, 6), $sformatf("r-type f3=%0d alt=%0d", f3, alt),
                    4*n_instr + 4, 1, arith_ref(f3, alt, va, vb));
                if (alt == 1 && f3 == 0) continue; // no subi
                imm = (f3 == 1 || f3 == 5) ? {21'b0, alt[0], 5'b0, vb[4:0]} : vb;
                put(i_type(rv_isa_pkg::OP_IMM, f3, 10, 5, imm[11:0]),
                    $sformatf("i-type f3=%0d alt=%0d", f3, alt),
                    4*n_instr + 4, 1, arith_ref(f3, alt, va, imm));
            end
        end
        addr = 12'($urandom_range(0, 255) * 4); // aligned word inside the 1 KiB ram
        vw   = (vb << 16) ^ va;
        put(i_type(rv_isa_pkg::OP_IMM, 0, 8, 0, addr), "addi x8", 4*n_instr + 4, 0, 0);
        put(i_type(rv_isa_pkg::OP_IMM, 1, 7, 6, 12'd16), "slli x7", 4*n_instr + 4, 0, 0);
        put(r_type(4, 0, 7, 7, 5), "xor x7", 4*n_instr + 4, 0, 0);
        put(s_type(rv_isa_pkg::F3_WORD, 8, 7, 0), "sw", 4*n_instr + 4, 0, 0);
        put(i_type(rv_isa_pkg::OP_LOAD, rv_isa_pkg::F3_WORD, 10, 8, 0), "lw",
            4*n_instr + 4, 1, vw);
        put(s_type(rv_isa_pkg::F3_BYTE, 8, 6, 1), "sb", 4*n_instr + 4, 0, 0); // byte 1
        put(i_type(rv_isa_pkg::OP_LOAD, rv_isa_pkg::F3_BYTE, 10, 8, 1), "lb",
            4*n_instr + 4, 1, {{24{vb[7]}}, vb[7:0]});
        put(i_type(rv_isa_pkg::OP_LOAD, rv_isa_pkg::F3_WORD, 10, 8, 0), "lw after sb",
            4*n_instr + 4, 1, {vw[31:16], vb[7:0], vw[7:0]}); // other bytes kept
        for (int b = 0; b < 4; b++) begin
            f3b = (b < 2) ? 3'(b) : 3'(b + 2); // beq, bne, blt, bge
            for (int p = 0; p < 3; p++) begin // (x5,x5) (x5,x6) (x6,x5)
                rs1   = (p == 2) ? 5'd6 : 5'd5;
                rs2   = (p == 0) ? 5'd5 : 5'd6;
                taken = branch_ref(f3b, (rs1 == 5) ? va : vb, (rs2 == 5) ? va : vb);
                put(b_type(f3b, rs1, rs2, 13'd8), $sformatf("branch f3=%0d pair=%0d", f3b, p),
                    4*n_instr + (taken ? 8 : 4), 0, 0);
                put(NOP, "nop", 4*n_instr + 4, 0, 0); // skipped when taken
            end
        end
        k = $urandom_range(2, 4);
        put(jal_enc(10, 21'(4*k)), "jal", 4*n_instr + 4*k, 1, 4*n_instr + 4);
        repeat (k - 1) put(FILL, "skipped", 4*n_instr + 4, 0, 0);
        tgt = 4*n_instr + 16; // past addi, jalr and two fillers
        put(i_type(rv_isa_pkg::OP_IMM, 0, 9, 0, 12'(tgt - 7)), "addi x9", 4*n_instr + 4, 0, 0);
        put(i_type(rv_isa_pkg::OP_JALR, 0, 10, 9, 12'd8), "jalr", tgt, 1, 4*n_instr + 4);
        repeat (2) put(FILL, "skipped", 4*n_instr + 4, 0, 0);
        put(i_type(rv_isa_pkg::OP_IMM, 0, 0, 0, 12'h7ff), "addi x0", 4*n_instr + 4, 0, 0);
        put(i_type(rv_isa_pkg::OP_IMM, 0, 10, 0, 12'd0), "mv x10 x0", 4*n_instr + 4, 1, 0);
        cycles = 0;
        while (!prog_done && cycles < LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!prog_done) begin
            other_errs++;
            $display("timeout: program end never fetched, pc is %h", pc);
        end
        $display("errors: %0d value, %0d other", val_errs, other_errs);
        if (val_errs + other_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: build.f
hw/rv_isa_pkg.sv
hw/rv_ctrl_pkg.sv
hw/control.sv
hw/imm_extend.sv
hw/alu.sv
hw/pc_unit.sv
hw/reg_file.sv
hw/data_ram.sv
hw/cpu_top.sv
bench/tb_clk_gen.sv
bench/tb_cpu.sv

// File: hw/alu.sv
`timescale 1ns/1ns

module alu (
    input  rv_isa_pkg::word_t    src_a_i,       // register read port 1
    input  rv_isa_pkg::word_t    reg_b_i,       // register read port 2
    input  rv_isa_pkg::word_t    imm_i,         // extended immediate
    input  logic                 alu_src_i,     // 1 takes imm as src_b
    input  rv_ctrl_pkg::alu_op_t alu_ctrl_i,    // operation
    output rv_isa_pkg::word_t    result_o,      // arithmetic result or address
    output logic                 branch_take_o  // jump or condition met
);

    rv_isa_pkg::word_t src_b;   // selected second operand
    logic [4:0]        shamt;   // low 5 bits only
    logic              lt_s;    // signed less than
    logic              lt_u;    // unsigned less than
    logic              eq;

    assign src_b = alu_src_i ? imm_i : reg_b_i;
    assign shamt = src_b[4:0];
    assign lt_s  = $signed(src_a_i) < $signed(src_b);
    assign lt_u  = src_a_i < src_b;
    assign eq    = src_a_i == src_b;

    always_comb begin
        result_o      = '0;
        branch_take_o = 1'b0;
        case (alu_ctrl_i)
            rv_ctrl_pkg::ALU_ADD:    result_o = src_a_i + src_b;
            rv_ctrl_pkg::ALU_SUB:    result_o = src_a_i - src_b;
            rv_ctrl_pkg::ALU_AND:    result_o = src_a_i & src_b;
            rv_ctrl_pkg::ALU_OR:     result_o = src_a_i | src_b;
            rv_ctrl_pkg::ALU_XOR:    result_o = src_a_i ^ src_b;
            rv_ctrl_pkg::ALU_SLT:    result_o = {31'b0, lt_s};
            rv_ctrl_pkg::ALU_SLTU:   result_o = {31'b0, lt_u};
            rv_ctrl_pkg::ALU_SRL:    result_o = src_a_i >> shamt;
            rv_ctrl_pkg::ALU_SLL:    result_o = src_a_i << shamt;
            rv_ctrl_pkg::ALU_SRA:    result_o = $signed(src_a_i) >>> shamt; // keeps sign
            rv_ctrl_pkg::ALU_PASSBJ: begin
                result_o      = src_b;
                branch_take_o = 1'b1;
            end
            rv_ctrl_pkg::ALU_ADDJ: begin
                result_o      = src_a_i + src_b; // jalr target before bit 0 clear
                branch_take_o = 1'b1;
            end
            rv_ctrl_pkg::ALU_BEQ:    branch_take_o = eq;
            rv_ctrl_pkg::ALU_BNE:    branch_take_o = !eq;
            rv_ctrl_pkg::ALU_BLT:    branch_take_o = lt_s;
            default:                 branch_take_o = !lt_s; // bge
        endcase
    end

endmodule

// File: hw/control.sv
`timescale 1ns/1ns

module control (
    input  rv_isa_pkg::opcode_t   op_i,           // instr[6:0]
    input  rv_isa_pkg::funct3_t   funct3_i,       // instr[14:12]
    input  logic                  funct7bit_i,    // instr[30]
    output logic                  mem_write_en_o, // store strobe
    output logic                  reg_write_en_o, // register write enable
    output rv_ctrl_pkg::alu_op_t  alu_ctrl_o,     // alu operation
    output logic                  alu_src_o,      // 1 selects imm as src_b
    output rv_ctrl_pkg::imm_src_t imm_src_o,      // immediate format
    output logic                  branch_src_o,   // lets branch_take move the pc
    output logic                  addr_select_o,  // 1 word, 0 byte access
    output logic                  result_src_o,   // 1 writes back ram data
    output logic                  jal_o,          // writes back pc + 4
    output logic                  jalr_o          // pc from alu result
);

    rv_ctrl_pkg::alu_op_t arith_op; // op for R and I arithmetic

    always_comb begin
        case (funct3_i)
            rv_isa_pkg::F3_ADD_SUB: // sub only exists as R-type
                arith_op = (funct7bit_i && op_i == rv_isa_pkg::OP_R) ?
                           rv_ctrl_pkg::ALU_SUB : rv_ctrl_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:  arith_op = rv_ctrl_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:  arith_op = rv_ctrl_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU: arith_op = rv_ctrl_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:  arith_op = rv_ctrl_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL_SRA: // srai keeps bit 30 in its imm field
                arith_op = funct7bit_i ? rv_ctrl_pkg::ALU_SRA : rv_ctrl_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:   arith_op = rv_ctrl_pkg::ALU_OR;
            default:             arith_op = rv_ctrl_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        mem_write_en_o = 1'b0; // unknown opcodes fall through as nop
        reg_write_en_o = 1'b0;
        alu_ctrl_o     = rv_ctrl_pkg::ALU_ADD;
        alu_src_o      = 1'b0;
        imm_src_o      = rv_ctrl_pkg::IMM_I;
        branch_src_o   = 1'b0;
        addr_select_o  = (funct3_i == rv_isa_pkg::F3_WORD); // lw/sw vs lb/sb
        result_src_o   = 1'b0;
        jal_o          = 1'b0;
        jalr_o         = 1'b0;
        case (op_i)
            rv_isa_pkg::OP_R: begin
                reg_write_en_o = 1'b1;
                alu_ctrl_o     = arith_op;
            end
            rv_isa_pkg::OP_IMM: begin
                reg_write_en_o = 1'b1;
                alu_src_o      = 1'b1;
                alu_ctrl_o     = arith_op;
            end
            rv_isa_pkg::OP_LOAD: begin
                reg_write_en_o = 1'b1;
                alu_src_o      = 1'b1; // rs1 + imm address
                result_src_o   = 1'b1;
            end
            rv_isa_pkg::OP_STORE: begin
                mem_write_en_o = 1'b1;
                alu_src_o      = 1'b1;
                imm_src_o      = rv_ctrl_pkg::IMM_S;
            end
            rv_isa_pkg::OP_BRANCH: begin
                imm_src_o    = rv_ctrl_pkg::IMM_B;
                branch_src_o = 1'b1;
                case (funct3_i)
                    rv_isa_pkg::F3_BEQ: alu_ctrl_o = rv_ctrl_pkg::ALU_BEQ;
                    rv_isa_pkg::F3_BNE: alu_ctrl_o = rv_ctrl_pkg::ALU_BNE;
                    rv_isa_pkg::F3_BLT: alu_ctrl_o = rv_ctrl_pkg::ALU_BLT;
                    rv_isa_pkg::F3_BGE: alu_ctrl_o = rv_ctrl_pkg::ALU_BGE;
                    default: branch_src_o = 1'b0; // bltu/bgeu never taken
                endcase
            end
            rv_isa_pkg::OP_JAL: begin
                reg_write_en_o = 1'b1;
                alu_src_o      = 1'b1;
                imm_src_o      = rv_ctrl_pkg::IMM_J;
                branch_src_o   = 1'b1; // pc + imm
                jal_o          = 1'b1;
                alu_ctrl_o     = rv_ctrl_pkg::ALU_PASSBJ; // only branch_take used
            end
            rv_isa_pkg::OP_JALR: begin
                reg_write_en_o = 1'b1;
                alu_src_o      = 1'b1;
                branch_src_o   = 1'b1;
                jal_o          = 1'b1; // link address
                jalr_o         = 1'b1;
                alu_ctrl_o     = rv_ctrl_pkg::ALU_ADDJ; // rs1 + imm target
            end
            default: ;
        endcase
    end

endmodule

// File: hw/cpu_top.sv
`timescale 1ns/1ns

module cpu_top #(
    parameter int RAM_ADDR_W = 10 // data ram size, log2 bytes
) (
    input  logic              clk_i,
    input  logic              rst_n_i,  // async, active low
    input  rv_isa_pkg::word_t instr_i,  // from external program store
    output rv_isa_pkg::word_t pc_o,     // fetch address
    output rv_isa_pkg::word_t a0_o      // x10
);

    wire rv_isa_pkg::reg_idx_t rs1_idx = instr_i[19:15];
    wire rv_isa_pkg::reg_idx_t rs2_idx = instr_i[24:20];
    wire rv_isa_pkg::reg_idx_t rd_idx  = instr_i[11:7];

    logic                  mem_write;   // decode outputs
    logic                  reg_write;
    rv_ctrl_pkg::alu_op_t  alu_op;
    logic                  alu_src;
    rv_ctrl_pkg::imm_src_t imm_src;
    logic                  branch_src;
    logic                  addr_select;
    logic                  result_src;
    logic                  jal;
    logic                  jalr;
    rv_isa_pkg::word_t     imm;

    rv_isa_pkg::word_t     rd1;         // register read ports
    rv_isa_pkg::word_t     rd2;
    rv_isa_pkg::word_t     alu_result;  // execute outputs
    logic                  branch_take;
    rv_isa_pkg::word_t     pc_plus4;
    rv_isa_pkg::word_t     read_data;   // ram to write-back

    control u_control (
        .op_i           (instr_i[6:0]),
        .funct3_i       (instr_i[14:12]),
        .funct7bit_i    (instr_i[30]),
        .mem_write_en_o (mem_write),
        .reg_write_en_o (reg_write),
        .alu_ctrl_o     (alu_op),
        .alu_src_o      (alu_src),
        .imm_src_o      (imm_src),
        .branch_src_o   (branch_src),
        .addr_select_o  (addr_select),
        .result_src_o   (result_src),
        .jal_o          (jal),
        .jalr_o         (jalr)
    );

    imm_extend u_imm_extend (.instr_i(instr_i), .imm_src_i(imm_src), .imm_o(imm));

    alu u_alu (
        .src_a_i       (rd1),
        .reg_b_i       (rd2),
        .imm_i         (imm),
        .alu_src_i     (alu_src),
        .alu_ctrl_i    (alu_op),
        .result_o      (alu_result),
        .branch_take_o (branch_take)
    );

    pc_unit u_pc_unit (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .branch_src_i  (branch_src),
        .branch_take_i (branch_take),
        .jalr_i        (jalr),
        .imm_i         (imm),
        .alu_result_i  (alu_result),
        .pc_o          (pc_o),
        .pc_plus4_o    (pc_plus4)
    );

    reg_file u_reg_file (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .rs1_i        (rs1_idx),
        .rs2_i        (rs2_idx),
        .rd_i         (rd_idx),
        .we_i         (reg_write),
        .jal_i        (jal),
        .result_src_i (result_src),
        .alu_result_i (alu_result),
        .read_data_i  (read_data),
        .pc_plus4_i   (pc_plus4),
        .rd1_o        (rd1),
        .rd2_o        (rd2),
        .a0_o         (a0_o)
    );

    data_ram #(.RAM_ADDR_W(RAM_ADDR_W)) u_data_ram (
        .clk_i         (clk_i),
        .addr_i        (alu_result),
        .wdata_i       (rd2),
        .we_i          (mem_write),
        .addr_select_i (addr_select),
        .funct3_i      (instr_i[14:12]),
        .rdata_o       (read_data)
    );

endmodule

// File: hw/data_ram.sv
`timescale 1ns/1ns

module data_ram #(
    parameter int RAM_ADDR_W = 10 // log2 of size in bytes
) (
    input  logic                clk_i,
    input  rv_isa_pkg::word_t   addr_i,        // byte address from alu
    input  rv_isa_pkg::word_t   wdata_i,       // read port 2
    input  logic                we_i,          // store strobe
    input  logic                addr_select_i, // 1 word, 0 byte
    input  rv_isa_pkg::funct3_t funct3_i,      // bit 2 set on unsigned loads
    output rv_isa_pkg::word_t   rdata_o
);

    logic [7:0]            mem [2**RAM_ADDR_W]; // little-endian bytes
    logic [RAM_ADDR_W-1:0] byte_addr;           // wraps modulo size
    logic [RAM_ADDR_W-3:0] word_idx;            // aligned word number
    rv_isa_pkg::word_t     word_rd;
    logic [7:0]            byte_rd;

    assign byte_addr = addr_i[RAM_ADDR_W-1:0];
    assign word_idx  = byte_addr[RAM_ADDR_W-1:2]; // low two bits ignored on words

    assign word_rd = {mem[{word_idx, 2'd3}], mem[{word_idx, 2'd2}],
                      mem[{word_idx, 2'd1}], mem[{word_idx, 2'd0}]};
    assign byte_rd = mem[byte_addr];

    assign rdata_o = addr_select_i ? word_rd :
                     funct3_i[2]   ? {24'b0, byte_rd} :
                                     {{24{byte_rd[7]}}, byte_rd}; // lb sign extend

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            if (addr_select_i) begin // sw
                mem[{word_idx, 2'd0}] <= wdata_i[7:0];
                mem[{word_idx, 2'd1}] <= wdata_i[15:8];
                mem[{word_idx, 2'd2}] <= wdata_i[23:16];
                mem[{word_idx, 2'd3}] <= wdata_i[31:24];
            end else begin // sb, neighbours untouched
                mem[byte_addr] <= wdata_i[7:0];
            end
        end
    end

endmodule

// File: hw/imm_extend.sv
`timescale 1ns/1ns

module imm_extend (
    input  rv_isa_pkg::word_t     instr_i,   // full instruction word
    input  rv_ctrl_pkg::imm_src_t imm_src_i, // format from control
    output rv_isa_pkg::word_t     imm_o      // sign-extended immediate
);

    always_comb begin
        case (imm_src_i)
            rv_ctrl_pkg::IMM_S: // store offset split around rd field
                imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            rv_ctrl_pkg::IMM_B: // branch offset, halfword aligned
                imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
            rv_ctrl_pkg::IMM_J: // jal offset, halfword aligned
                imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};
            default: // I format, also jalr and loads
                imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
        endcase
    end

endmodule

// File: hw/pc_unit.sv
`timescale 1ns/1ns

module pc_unit (
    input  logic              clk_i,
    input  logic              rst_n_i,       // async, active low
    input  logic              branch_src_i,  // branch or jal in flight
    input  logic              branch_take_i, // condition from alu
    input  logic              jalr_i,        // target from alu
    input  rv_isa_pkg::word_t imm_i,         // pc-relative offset
    input  rv_isa_pkg::word_t alu_result_i,  // jalr target
    output rv_isa_pkg::word_t pc_o,          // current pc
    output rv_isa_pkg::word_t pc_plus4_o     // link / sequential address
);

    rv_isa_pkg::word_t pc_next;

    assign pc_plus4_o = pc_o + 32'd4;

    always_comb begin
        if (jalr_i) begin
            pc_next = {alu_result_i[31:1], 1'b0}; // lsb cleared per spec
        end else if (branch_src_i && branch_take_i) begin
            pc_next = pc_o + imm_i;
        end else begin
            pc_next = pc_plus4_o;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_o <= '0; // fetch starts at 0
        end else begin
            pc_o <= pc_next;
        end
    end

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic                 clk_i,
    input  logic                 rst_n_i,      // clears all registers
    input  rv_isa_pkg::reg_idx_t rs1_i,        // read port 1 index
    input  rv_isa_pkg::reg_idx_t rs2_i,        // read port 2 index
    input  rv_isa_pkg::reg_idx_t rd_i,         // write index
    input  logic                 we_i,         // write enable
    input  logic                 jal_i,        // link write-back
    input  logic                 result_src_i, // load write-back
    input  rv_isa_pkg::word_t    alu_result_i,
    input  rv_isa_pkg::word_t    read_data_i,  // from data_ram
    input  rv_isa_pkg::word_t    pc_plus4_i,
    output rv_isa_pkg::word_t    rd1_o,
    output rv_isa_pkg::word_t    rd2_o,
    output rv_isa_pkg::word_t    a0_o          // x10 tap for the bench
);

    rv_isa_pkg::word_t regs [32];
    rv_isa_pkg::word_t wb_data; // selected write-back value

    assign wb_data = jal_i        ? pc_plus4_i  :
                     result_src_i ? read_data_i : alu_result_i;

    assign rd1_o = (rs1_i == '0) ? '0 : regs[rs1_i]; // x0 hardwired
    assign rd2_o = (rs2_i == '0) ? '0 : regs[rs2_i];
    assign a0_o  = regs[10];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin // writes to x0 dropped
            regs[rd_i] <= wb_data;
        end
    end

endmodule

// File: hw/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

    // alu operation, loads and stores form their address with ALU_ADD
    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SUB    = 4'b0001,
        ALU_AND    = 4'b0010,
        ALU_OR     = 4'b0011,
        ALU_XOR    = 4'b0100,
        ALU_SLT    = 4'b0101, // signed compare
        ALU_SLTU   = 4'b0110, // unsigned compare
        ALU_SRL    = 4'b0111,
        ALU_SLL    = 4'b1000,
        ALU_SRA    = 4'b1001,
        ALU_BEQ    = 4'b1010,
        ALU_PASSBJ = 4'b1011, // forward src_b, force branch_take
        ALU_ADDJ   = 4'b1100, // add, force branch_take
        ALU_BNE    = 4'b1101,
        ALU_BLT    = 4'b1110,
        ALU_BGE    = 4'b1111
    } alu_op_t;

    // immediate format for imm_extend
    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_J = 3'b100
    } imm_src_t;

endpackage

// File: hw/rv_isa_pkg.sv
package rv_isa_pkg;

    typedef logic [31:0] word_t;    // data or address word
    typedef logic [6:0]  opcode_t;  // instr[6:0]
    typedef logic [2:0]  funct3_t;  // instr[14:12]
    typedef logic [4:0]  reg_idx_t; // rs1, rs2, rd fields

    // major opcodes of the supported subset
    localparam opcode_t OP_R      = 7'b0110011; // register-register arithmetic
    localparam opcode_t OP_IMM    = 7'b0010011; // register-immediate arithmetic
    localparam opcode_t OP_LOAD   = 7'b0000011; // lb, lw
    localparam opcode_t OP_STORE  = 7'b0100011; // sb, sw
    localparam opcode_t OP_BRANCH = 7'b1100011; // beq, bne, blt, bge
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_JAL    = 7'b1101111;

    // funct3 for arithmetic
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // funct3 for branches
    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;
    localparam funct3_t F3_BLT = 3'b100;
    localparam funct3_t F3_BGE = 3'b101;

    // funct3 for loads and stores, bit 2 marks unsigned loads
    localparam funct3_t F3_BYTE = 3'b000;
    localparam funct3_t F3_WORD = 3'b010;

endpackage
